// ==== compile.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/instDecoder.sv
hdl/seqController.sv
hdl/aluExec.sv
hdl/regWriteback.sv
hdl/cpuCore.sv
tb/cpuCore_asserts.sv
tb/cpuCore_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := cpuCore_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/cpuCore_tb.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"
`default_nettype none

module cpuCore_tb;

	logic                   CLK;
	logic                   arstN;
	logic [`CPU_ADDR_W-1:0] instAddr;
	logic [15:0]            instData;
	logic                   memReqValid;
	logic                   memReqReady;
	cpuPkg::memReqS         memReq;
	logic                   memRspValid;
	logic [`CPU_DATA_W-1:0] memRspData;

	logic [15:0] progMem [64];
	logic [15:0] dataMem [65536];  // Memory behind the DUT's data port
	logic [15:0] modelMem [65536]; // Memory of the architectural model
	logic [31:0] expStore [256];   // Expected stores as {addr, data}, in program order
	logic [15:0] expPc [256];      // Every new PC value the program should show
	logic [7:0]  storeTotal;
	logic [7:0]  pcTotal;
	logic [7:0]  storeIdx;         // Stores seen so far at the port
	logic [7:0]  pcIdx;
	logic [5:0]  progLen;
	logic [15:0] lastAddr;
	logic [15:0] haltAddr;         // Address of the final jump-to-self
	logic [31:0] lcgState;
	logic        rspPending;
	logic [1:0]  rspDelay;
	logic [15:0] rspData;
	int          errorCount;

	cpuCore cpuCore_inst (.*);

	assign instData = progMem[instAddr[5:0]]; // Instruction port answers in the same cycle

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte swap and invert, so every address bit shows up in the word
	function automatic logic [15:0] fillWord(input logic [15:0] a);
		return ~{a[7:0], a[15:8]};
	endfunction

	function automatic logic [15:0] regWord(input logic [3:0] op, rd, ext, rs);
		return {op, rd, ext, rs};
	endfunction

	function automatic logic [15:0] immWord(input logic [3:0] op, rd, input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	task automatic appendWord(input logic [15:0] word);
		progMem[progLen] = word;
		progLen = progLen + 6'd1;
	endtask

	// Target in r9, compare, jump, then a marker bit in r10 that only a fall-through sets
	task automatic addBranchTest(input logic [15:0] cmpWord, input logic [3:0] cond,
			input logic [7:0] marker);
		appendWord(immWord(cpuPkg::MOVI, 4'd9, {2'b00, progLen} + 8'd4));
		appendWord(cmpWord);
		appendWord(regWord(cpuPkg::MEM, 4'd9, cpuPkg::JCOND, cond));
		appendWord(immWord(cpuPkg::ORI, 4'd10, marker));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program image
	////////////////////////////////////////////////////////////////////////////

	task automatic buildProgram();
		progMem = '{default: 16'h0000}; // Unused words decode as no-ops
		progLen = '0;
		appendWord(immWord(cpuPkg::MOVI, 4'd1, 8'h34));                       // Address A
		appendWord(immWord(cpuPkg::MOVI, 4'd2, 8'h80));                       // Address B
		appendWord(regWord(cpuPkg::MEM, 4'd3, cpuPkg::LOAD, 4'd2));           // Fill gives 7fff
		appendWord(immWord(cpuPkg::ADDI, 4'd3, 8'h01));                       // Signed overflow
		appendWord(regWord(cpuPkg::MEM, 4'd3, cpuPkg::STOR, 4'd1));
		appendWord(regWord(cpuPkg::MEM, 4'd6, cpuPkg::LOAD, 4'd1));           // Read it back
		appendWord(regWord(cpuPkg::MEM, 4'd6, cpuPkg::STOR, 4'd2));
		appendWord(immWord(cpuPkg::SUBI, 4'd4, 8'h01));                       // Borrow out of zero
		appendWord(regWord(cpuPkg::REGOP, 4'd4, cpuPkg::ADD, 4'd3));          // Carry out
		appendWord(regWord(cpuPkg::REGOP, 4'd4, cpuPkg::XOR, 4'd1));
		appendWord(regWord(cpuPkg::REGOP, 4'd5, cpuPkg::SUB, 4'd4));
		appendWord(immWord(cpuPkg::ORI, 4'd5, 8'h0f));
		appendWord(regWord(cpuPkg::REGOP, 4'd5, cpuPkg::AND, 4'd4));
		appendWord(regWord(cpuPkg::REGOP, 4'd5, cpuPkg::OR, 4'd3));
		appendWord(immWord(cpuPkg::ANDI, 4'd4, 8'h3c));
		appendWord(regWord(cpuPkg::REGOP, 4'd7, cpuPkg::MOV, 4'd5));
		appendWord(regWord(cpuPkg::MEM, 4'd4, cpuPkg::STOR, 4'd1));
		appendWord(regWord(cpuPkg::MEM, 4'd7, cpuPkg::STOR, 4'd2));
		// Equal, lower and higher operands for each kind of compare
		addBranchTest(regWord(cpuPkg::REGOP, 4'd1, cpuPkg::CMP, 4'd1), cpuPkg::BEQ, 8'h01);
		addBranchTest(regWord(cpuPkg::REGOP, 4'd1, cpuPkg::CMP, 4'd2), cpuPkg::BLT, 8'h02);
		addBranchTest(regWord(cpuPkg::REGOP, 4'd1, cpuPkg::CMP, 4'd2), cpuPkg::BGE, 8'h04);
		addBranchTest(regWord(cpuPkg::REGOP, 4'd2, cpuPkg::CMP, 4'd1), cpuPkg::BGT, 8'h01);
		addBranchTest(immWord(cpuPkg::CMPI, 4'd1, 8'h34), cpuPkg::BEQ, 8'h02);
		addBranchTest(immWord(cpuPkg::CMPI, 4'd2, 8'h10), cpuPkg::BGT, 8'h08);
		addBranchTest(immWord(cpuPkg::CMPI, 4'd1, 8'hff), cpuPkg::BGE, 8'h10);
		addBranchTest(immWord(cpuPkg::CMPUI, 4'd1, 8'h34), cpuPkg::BNEQ, 8'h20);
		addBranchTest(immWord(cpuPkg::CMPUI, 4'd1, 8'hff), cpuPkg::BLE, 8'h40);
		addBranchTest(immWord(cpuPkg::CMPUI, 4'd2, 8'h34), cpuPkg::BLE, 8'h80);
		appendWord(regWord(cpuPkg::MEM, 4'd10, cpuPkg::STOR, 4'd1));          // Markers
		appendWord(regWord(cpuPkg::MEM, 4'd1, cpuPkg::STOR, 4'd2)); // r1 survived the compares
		appendWord(immWord(cpuPkg::MOVI, 4'd9, {2'b00, progLen} + 8'd1));
		appendWord(regWord(cpuPkg::MEM, 4'd9, cpuPkg::JCOND, cpuPkg::JUC));   // Halt loop
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Architectural model, run once before reset is released
	////////////////////////////////////////////////////////////////////////////

	task automatic runModel();
		logic [15:0] regs [16];
		logic [15:0] pc;
		logic [15:0] nextPc;
		logic [15:0] inst;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [3:0]  code;
		logic        flagZ;
		logic        flagL;
		logic        take;
		logic        halted;
		int          steps;
		regs = '{default: 16'h0000};
		pc = '0;
		flagZ = 1'b0;
		flagL = 1'b0;
		halted = 1'b0;
		steps = 0;
		storeTotal = '0;
		expPc[0] = '0;
		pcTotal = 8'd1;
		while (!halted && steps < 200) begin
			inst = progMem[pc[5:0]];
			a = regs[inst[11:8]];
			b = regs[inst[3:0]];
			code = inst[7:4];
			nextPc = pc + 16'd1;
			// Immediate forms act as the register form of the same operation
			case (inst[15:12])
				cpuPkg::ADDI:  {code, b} = {cpuPkg::ADD, {{8{inst[7]}}, inst[7:0]}};
				cpuPkg::SUBI:  {code, b} = {cpuPkg::SUB, {{8{inst[7]}}, inst[7:0]}};
				cpuPkg::CMPI:  {code, b} = {cpuPkg::CMP, {{8{inst[7]}}, inst[7:0]}};
				cpuPkg::ANDI:  {code, b} = {cpuPkg::AND, 8'h00, inst[7:0]};
				cpuPkg::ORI:   {code, b} = {cpuPkg::OR, 8'h00, inst[7:0]};
				cpuPkg::MOVI:  {code, b} = {cpuPkg::MOV, 8'h00, inst[7:0]};
				cpuPkg::CMPUI: {code, b} = {cpuPkg::CMP, 8'h00, inst[7:0]};
				default: ;
			endcase
			if (inst[15:12] == cpuPkg::MEM) begin
				case (code)
					cpuPkg::LOAD: regs[inst[11:8]] = modelMem[b];
					cpuPkg::STOR: begin
						modelMem[b] = a;
						expStore[storeTotal] = {b, a};
						storeTotal = storeTotal + 8'd1;
					end
					cpuPkg::JCOND: begin
						case (inst[3:0])
							cpuPkg::JUC:  take = 1'b1;
							cpuPkg::BEQ:  take = flagZ;
							cpuPkg::BNEQ: take = !flagZ;
							cpuPkg::BGT:  take = !flagL && !flagZ;
							cpuPkg::BLT:  take = flagL;
							cpuPkg::BGE:  take = !flagL;
							cpuPkg::BLE:  take = flagL || flagZ;
							default:      take = 1'b0;
						endcase
						if (take)
							nextPc = a; // Target sits in the data register field
						halted = take && (a == pc);
					end
					default: ;
				endcase
			end else begin
				case (code)
					cpuPkg::ADD:             res = a + b;
					cpuPkg::SUB, cpuPkg::CMP: res = a - b;
					cpuPkg::AND:             res = a & b;
					cpuPkg::OR:              res = a | b;
					cpuPkg::XOR:             res = a ^ b;
					default:                 res = b;
				endcase
				if (code != cpuPkg::MOV) begin
					flagZ = (res == 16'h0000);
					flagL = (code == cpuPkg::SUB || code == cpuPkg::CMP) && (a < b);
				end
				if (code != cpuPkg::CMP)
					regs[inst[11:8]] = res;
			end
			if (nextPc != pc) begin
				expPc[pcTotal] = nextPc;
				pcTotal = pcTotal + 8'd1;
			end
			pc = nextPc;
			steps++;
		end
		haltAddr = pc;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Data memory with random back-pressure and response delay
	////////////////////////////////////////////////////////////////////////////

	always @(posedge CLK) begin
		lcgState = lcgNext(lcgState);
		memReqReady <= (lcgState[21:20] != 2'b00); // Ready about three cycles in four
		memRspValid <= 1'b0;
		if (rspPending) begin
			if (rspDelay == 2'd0) begin
				memRspValid <= 1'b1;
				memRspData <= rspData;
				rspPending = 1'b0;
			end else begin
				rspDelay = rspDelay - 2'd1;
			end
		end
		if (memReqValid && memReqReady) begin
			if (memReq.write) begin
				dataMem[memReq.addr] = memReq.wrData; // Stores get no response
			end else begin
				rspData = dataMem[memReq.addr];
				rspDelay = lcgState[25:24];
				rspPending = 1'b1;
			end
		end
	end

	// Progress counters that the checks index with
	always @(posedge CLK) begin
		lastAddr <= instAddr;
		if (arstN && instAddr != lastAddr)
			pcIdx <= pcIdx + 8'd1;
		if (arstN && memReqValid && memReqReady && memReq.write)
			storeIdx <= storeIdx + 8'd1;
	end

	storeCheck: assert property (@(posedge CLK) disable iff (!arstN)
		(memReqValid && memReqReady && memReq.write) |->
			(storeIdx < storeTotal && {memReq.addr, memReq.wrData} == expStore[storeIdx]))
		else begin
			errorCount++;
			$display("error at %0t: store of %h to %h, model expects {addr, data} %h",
				$time, memReq.wrData, memReq.addr, expStore[storeIdx]);
		end

	// Taken and skipped jumps show up in the order of PC values
	pcCheck: assert property (@(posedge CLK) disable iff (!arstN)
		(instAddr != lastAddr) |-> (pcIdx < pcTotal && instAddr == expPc[pcIdx]))
		else begin
			errorCount++;
			$display("error at %0t: PC moved to %h, model expects %h",
				$time, instAddr, expPc[pcIdx]);
		end

	initial begin
		logic [15:0] fillAddr;
		int          cycles;
		arstN = 1'b0;
		memReqReady = 1'b0;
		memRspValid = 1'b0;
		memRspData = '0;
		errorCount = 0;
		storeIdx = '0;
		pcIdx = 8'd1; // Address 0 is already showing
		lastAddr = '0;
		lcgState = 32'h3c4f_bfc6;
		rspPending = 1'b0;
		rspDelay = '0;
		rspData = '0;
		fillAddr = '0;
		do begin
			dataMem[fillAddr] = fillWord(fillAddr);
			modelMem[fillAddr] = fillWord(fillAddr);
			fillAddr = fillAddr + 16'd1;
		end while (fillAddr != 16'h0000);
		buildProgram();
		runModel();
		repeat (5) @(posedge CLK);
		arstN <= 1'b1;

		cycles = 0;
		while (!(instAddr == haltAddr && storeIdx == storeTotal) && cycles < 3000) begin
			@(posedge CLK);
			cycles++;
		end
		if (cycles >= 3000) begin
			errorCount++;
			$display("timeout: the core never reached its halt loop after %0d cycles", cycles);
		end
		@(posedge CLK);
		finalCount: assert (pcIdx == pcTotal && storeIdx == storeTotal)
			else begin
				errorCount++;
				$display("error at %0t: saw %0d PC values and %0d stores, model has %0d and %0d",
					$time, pcIdx, storeIdx, pcTotal, storeTotal);
			end

		$display("check summary: %0d testbench errors, %0d bound assertion failures",
			errorCount, cpuCore_inst.cpuCore_asserts_inst.failCount);
		if (errorCount == 0 && cpuCore_inst.cpuCore_asserts_inst.failCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/cpuCore_asserts.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"
`default_nettype none

module cpuCore_asserts (
	input logic                   CLK,
	input logic                   arstN,
	input logic [`CPU_ADDR_W-1:0] instAddr,
	input logic                   memReqValid,
	input logic                   memReqReady,
	input cpuPkg::memReqS         memReq
);

	int failCount = 0; // Read by the testbench for its closing line

	////////////////////////////////////////////////////////////////////////////
	// Reset behavior
	////////////////////////////////////////////////////////////////////////////

	resetQuiet: assert property (@(posedge CLK) !arstN |-> (!memReqValid && instAddr == '0))
		else begin
			failCount++;
			$error("memory request or nonzero PC while reset is held");
		end

	// First cycle out of reset is a fetch from address 0
	firstFetch: assert property (@(posedge CLK) $rose(arstN) |-> (!memReqValid && instAddr == '0))
		else begin
			failCount++;
			$error("core did not start at address 0 after reset");
		end

	////////////////////////////////////////////////////////////////////////////
	// Data port handshake
	////////////////////////////////////////////////////////////////////////////

	requestHold: assert property (@(posedge CLK) disable iff (!arstN)
		(memReqValid && !memReqReady) |=> (memReqValid && $stable(memReq)))
		else begin
			failCount++;
			$error("request dropped or changed before it was accepted");
		end

endmodule

bind cpuCore cpuCore_asserts cpuCore_asserts_inst (
	.CLK         (CLK),
	.arstN       (arstN),
	.instAddr    (instAddr),
	.memReqValid (memReqValid),
	.memReqReady (memReqReady),
	.memReq      (memReq)
);

`default_nettype wire

// ==== hdl/cpuCore.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"
`default_nettype none

module cpuCore (
	input  logic                   CLK,
	input  logic                   arstN,
	output logic [`CPU_ADDR_W-1:0] instAddr,
	input  logic [15:0]            instData,
	output logic                   memReqValid,
	input  logic                   memReqReady,
	output cpuPkg::memReqS         memReq,
	input  logic                   memRspValid,
	input  logic [`CPU_DATA_W-1:0] memRspData
);

	cpuPkg::instU           instReg;
	cpuPkg::decodedS        dec;
	cpuPkg::aluFlagsS       nextFlags;
	logic [`CPU_DATA_W-1:0] aluResult;
	logic [`CPU_DATA_W-1:0] rdA;
	logic [`CPU_DATA_W-1:0] rdB;
	logic                   regWrite;
	logic                   selLoad;

	instDecoder instDecoder_inst (
		.inst (instReg),
		.dec  (dec)
	);

	seqController seqController_inst (
		.CLK         (CLK),
		.arstN       (arstN),
		.instData    (instData),
		.dec         (dec),
		.nextFlags   (nextFlags),
		.jumpTarget  (rdA), // Absolute target in the rDest register
		.memReqReady (memReqReady),
		.memRspValid (memRspValid),
		.instReg     (instReg),
		.instAddr    (instAddr),
		.memReqValid (memReqValid),
		.regWrite    (regWrite),
		.selLoad     (selLoad)
	);

	aluExec aluExec_inst (
		.dec       (dec),
		.srcA      (rdA),
		.srcB      (rdB),
		.result    (aluResult),
		.nextFlags (nextFlags)
	);

	regWriteback regWriteback_inst (
		.CLK       (CLK),
		.arstN     (arstN),
		.dec       (dec),
		.regWrite  (regWrite),
		.selLoad   (selLoad),
		.aluResult (aluResult),
		.loadData  (memRspData),
		.rdA       (rdA),
		.rdB       (rdB)
	);

	// Address from rSrc, data from rDest, both steady while the request waits
	assign memReq = '{addr: rdB, wrData: rdA, write: (dec.kind == cpuPkg::kindStore)};

endmodule

`default_nettype wire

// ==== hdl/regWriteback.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"
`default_nettype none

module regWriteback (
	input  logic                   CLK,
	input  logic                   arstN,
	input  cpuPkg::decodedS        dec,
	input  logic                   regWrite,  // One-cycle strobe from the controller
	input  logic                   selLoad,   // Pick load data over the ALU result
	input  logic [`CPU_DATA_W-1:0] aluResult,
	input  logic [`CPU_DATA_W-1:0] loadData,
	output logic [`CPU_DATA_W-1:0] rdA,
	output logic [`CPU_DATA_W-1:0] rdB
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];
	logic [`CPU_DATA_W-1:0] wrData;

	// Write-back source for the register named by rDest
	assign wrData = selLoad ? loadData : aluResult;

	////////////////////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			// Architectural state starts cleared
			for (int i = 0; i < `CPU_REG_N; i++)
				regs[i] <= '0;
		end else if (regWrite) begin
			regs[dec.rDest] <= wrData;
		end
	end

	// Asynchronous read ports
	assign rdA = regs[dec.rDest]; // Destination, store data and jump target
	assign rdB = regs[dec.rSrc];  // Source operand and memory address

endmodule

`default_nettype wire

// ==== hdl/aluExec.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"
`default_nettype none

module aluExec (
	input  cpuPkg::decodedS        dec,
	input  logic [`CPU_DATA_W-1:0] srcA,     // Register named by rDest
	input  logic [`CPU_DATA_W-1:0] srcB,     // Register named by rSrc
	output logic [`CPU_DATA_W-1:0] result,
	output cpuPkg::aluFlagsS       nextFlags
);

	localparam int MSB = `CPU_DATA_W - 1;

	logic [`CPU_DATA_W-1:0] opB;
	logic [`CPU_DATA_W:0]   sumWide;  // Extra bit is the carry out
	logic [`CPU_DATA_W:0]   diffWide; // Extra bit is the borrow

	assign opB = dec.useImm ? dec.immValue : srcB;
	assign sumWide = {1'b0, srcA} + {1'b0, opB};
	assign diffWide = {1'b0, srcA} - {1'b0, opB};

	////////////////////////////////////////////////////////////////////////////
	// Result and flags
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextFlags = '0;
		case (dec.aluOp)
			cpuPkg::aluAdd: begin
				result = sumWide[MSB:0];
				nextFlags.C = sumWide[`CPU_DATA_W];
				// Overflow when both operands share a sign the sum does not
				nextFlags.F = (srcA[MSB] == opB[MSB]) && (result[MSB] != srcA[MSB]);
			end
			cpuPkg::aluSub: begin
				result = diffWide[MSB:0]; // Destination minus source
				nextFlags.C = diffWide[`CPU_DATA_W];
				nextFlags.F = (srcA[MSB] != opB[MSB]) && (result[MSB] != srcA[MSB]);
			end
			cpuPkg::aluAnd: result = srcA & opB;
			cpuPkg::aluOr:  result = srcA | opB;
			cpuPkg::aluXor: result = srcA ^ opB;
			default:        result = opB; // Move copies the source or immediate
		endcase

		nextFlags.Z = (result == '0);
		if (dec.aluOp == cpuPkg::aluSub) begin
			// Compare semantics, the same bits serve SUB and SUBI
			nextFlags.L = (srcA < opB);
			nextFlags.N = ($signed(srcA) < $signed(opB));
		end else begin
			nextFlags.N = result[MSB]; // Sign of the result
		end
	end

endmodule

`default_nettype wire

// ==== hdl/seqController.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"
`default_nettype none

module seqController (
	input  logic                   CLK,
	input  logic                   arstN,
	input  logic [15:0]            instData,    // Answered combinationally on instAddr
	input  cpuPkg::decodedS        dec,
	input  cpuPkg::aluFlagsS       nextFlags,
	input  logic [`CPU_ADDR_W-1:0] jumpTarget,  // Value of the register named by rDest
	input  logic                   memReqReady,
	input  logic                   memRspValid,
	output cpuPkg::instU           instReg,
	output logic [`CPU_ADDR_W-1:0] instAddr,
	output logic                   memReqValid,
	output logic                   regWrite,
	output logic                   selLoad
);

	typedef enum logic [2:0] {
		fetch,  // Instruction memory answers on the PC
		decode, // Instruction register is valid, pick the next step
		alu,    // Write result and flags, advance the PC
		load1,  // Hold the read request until accepted
		load2,  // Wait for the read data
		stor1,  // Hold the write request until accepted
		stor2,  // Advance the PC after the write
		jump    // Load or advance the PC on the saved flags
	} stateE;

	stateE                  state;
	stateE                  nextState;
	logic [`CPU_ADDR_W-1:0] pc;
	cpuPkg::aluFlagsS       savedFlags; // Flags of the last flag-writing instruction
	logic                   takeJump;
	logic                   pcInc;
	logic                   pcLoad;

	////////////////////////////////////////////////////////////////////////////
	// State, program counter and saved flags
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= fetch;
			pc <= '0;
			savedFlags <= '0;
		end else begin
			state <= nextState;
			if (pcLoad) begin
				pc <= jumpTarget; // Absolute jump
			end else if (pcInc) begin
				pc <= pc + 1'b1;
			end
			if (state == alu && dec.writesFlags)
				savedFlags <= nextFlags; // Compares and arithmetic only
		end
	end

	// The word is latched at the end of fetch and held for the whole instruction
	always_ff @(posedge CLK) begin
		if (state == fetch)
			instReg <= cpuPkg::instU'(instData);
	end

	assign instAddr = pc;

	always_comb begin
		nextState = state;
		case (state)
			fetch:  nextState = decode;
			decode: begin
				case (dec.kind)
					cpuPkg::kindLoad:  nextState = load1;
					cpuPkg::kindStore: nextState = stor1;
					cpuPkg::kindJump:  nextState = jump;
					default:           nextState = alu;
				endcase
			end
			load1:  if (memReqReady) nextState = load2; // Handshake done
			load2:  if (memRspValid) nextState = fetch;
			stor1:  if (memReqReady) nextState = stor2;
			default: nextState = fetch; // alu, stor2 and jump all finish here
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Branch decision on the saved flags
	////////////////////////////////////////////////////////////////////////////

	// L holds the unsigned result of the last compare
	always_comb begin
		case (dec.cond)
			cpuPkg::JUC:  takeJump = 1'b1;
			cpuPkg::BEQ:  takeJump = savedFlags.Z;
			cpuPkg::BNEQ: takeJump = !savedFlags.Z;
			cpuPkg::BGT:  takeJump = !savedFlags.L && !savedFlags.Z;
			cpuPkg::BLT:  takeJump = savedFlags.L;
			cpuPkg::BGE:  takeJump = !savedFlags.L;
			cpuPkg::BLE:  takeJump = savedFlags.L || savedFlags.Z;
			default:      takeJump = 1'b0; // Undefined condition falls through
		endcase
	end

	// Outputs follow the registered state only, so the request is stable while waiting
	always_comb begin
		memReqValid = (state == load1) || (state == stor1);
		selLoad = (state == load2);
		regWrite = 1'b0;
		pcInc = 1'b0;
		pcLoad = 1'b0;
		case (state)
			alu: begin
				regWrite = dec.writesReg; // Compares leave the destination alone
				pcInc = 1'b1;
			end
			load2: begin
				regWrite = memRspValid; // Written on the response edge
				pcInc = memRspValid;
			end
			stor2: pcInc = 1'b1;
			jump: begin
				pcLoad = takeJump;
				pcInc = !takeJump;
			end
			default: pcInc = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/instDecoder.sv ====
`timescale 1ns/1ns
`include "cpu_cfg.svh"
`default_nettype none

module instDecoder (
	input  cpuPkg::instU    inst,
	output cpuPkg::decodedS dec
);

	logic [`CPU_DATA_W-1:0] immSext; // Used by arithmetic and the signed compare
	logic [`CPU_DATA_W-1:0] immZext; // Used by logic ops, MOVI and CMPUI

	assign immSext = {{(`CPU_DATA_W-8){inst.iForm.imm8[7]}}, inst.iForm.imm8};
	assign immZext = {{(`CPU_DATA_W-8){1'b0}}, inst.iForm.imm8};

	always_comb begin
		dec = '0; // Anything not matched below decodes as a no-op ALU step
		dec.rDest = inst.rForm.rDest;
		dec.rSrc = inst.rForm.rSrc;
		dec.cond = cpuPkg::condE'(inst.rForm.rSrc); // Only meaningful for JCOND
		dec.kind = cpuPkg::kindAlu;
		dec.aluOp = cpuPkg::aluMov;
		dec.useImm = (inst.rForm.op != cpuPkg::REGOP) && (inst.rForm.op != cpuPkg::MEM);
		dec.writesReg = 1'b1;
		dec.writesFlags = 1'b1;

		case (inst.rForm.op)
			cpuPkg::REGOP: begin
				case (inst.rForm.ext)
					cpuPkg::ADD: dec.aluOp = cpuPkg::aluAdd;
					cpuPkg::SUB: dec.aluOp = cpuPkg::aluSub;
					cpuPkg::AND: dec.aluOp = cpuPkg::aluAnd;
					cpuPkg::OR:  dec.aluOp = cpuPkg::aluOr;
					cpuPkg::XOR: dec.aluOp = cpuPkg::aluXor;
					cpuPkg::MOV: dec.writesFlags = 1'b0; // Moves leave the flags alone
					cpuPkg::CMP: begin
						dec.aluOp = cpuPkg::aluSub; // Compare is a subtract with no write
						dec.writesReg = 1'b0;
					end
					default: begin
						dec.writesReg = 1'b0;
						dec.writesFlags = 1'b0;
					end
				endcase
			end
			cpuPkg::ADDI: begin
				dec.aluOp = cpuPkg::aluAdd;
				dec.immValue = immSext;
			end
			cpuPkg::SUBI: begin
				dec.aluOp = cpuPkg::aluSub;
				dec.immValue = immSext;
			end
			cpuPkg::ANDI: begin
				dec.aluOp = cpuPkg::aluAnd;
				dec.immValue = immZext;
			end
			cpuPkg::ORI: begin
				dec.aluOp = cpuPkg::aluOr;
				dec.immValue = immZext;
			end
			cpuPkg::MOVI: begin
				dec.immValue = immZext;
				dec.writesFlags = 1'b0;
			end
			cpuPkg::CMPI, cpuPkg::CMPUI: begin
				dec.aluOp = cpuPkg::aluSub;
				dec.immValue = (inst.rForm.op == cpuPkg::CMPI) ? immSext : immZext;
				dec.writesReg = 1'b0;
			end
			cpuPkg::MEM: begin
				dec.writesFlags = 1'b0; // Memory and jump steps never touch the flags
				dec.writesReg = (inst.rForm.ext == cpuPkg::LOAD);
				case (inst.rForm.ext)
					cpuPkg::LOAD:  dec.kind = cpuPkg::kindLoad;
					cpuPkg::STOR:  dec.kind = cpuPkg::kindStore;
					cpuPkg::JCOND: dec.kind = cpuPkg::kindJump;
					default:       dec.kind = cpuPkg::kindAlu; // Unknown MEM code, skipped
				endcase
			end
			default: begin
				dec.writesReg = 1'b0;
				dec.writesFlags = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/cpuPkg.sv ====
`include "cpu_cfg.svh"
`default_nettype none

package cpuPkg;

	// Primary opcode in bits [15:12] of every instruction
	typedef enum logic [3:0] {
		REGOP = 4'b0000, // Register form ALU, operation in the extended code
		ANDI  = 4'b0001,
		ORI   = 4'b0010,
		MEM   = 4'b0100, // Load, store and absolute jump
		ADDI  = 4'b0101,
		SUBI  = 4'b1001,
		CMPI  = 4'b1011, // Signed immediate compare
		MOVI  = 4'b1101,
		CMPUI = 4'b1110  // Unsigned immediate compare
	} opCodeE;

	// Extended code in bits [7:4], meaning depends on the primary opcode
	typedef enum logic [3:0] {
		LOAD  = 4'b0000, // Under MEM
		AND   = 4'b0001,
		OR    = 4'b0010,
		XOR   = 4'b0011,
		STOR  = 4'b0100, // Under MEM
		ADD   = 4'b0101,
		SUB   = 4'b1001,
		CMP   = 4'b1011,
		JCOND = 4'b1100, // Under MEM, condition sits in the source field
		MOV   = 4'b1101
	} extCodeE;

	typedef enum logic [3:0] {
		BEQ  = 4'b0000,
		BNEQ = 4'b0001,
		BGT  = 4'b0110,
		BLT  = 4'b0111,
		BLE  = 4'b1100,
		BGE  = 4'b1101,
		JUC  = 4'b1110  // Unconditional
	} condE;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluMov} aluOpE;

	typedef enum logic [1:0] {kindAlu, kindLoad, kindStore, kindJump} kindE;

	// One instruction word, seen as register form or immediate form
	typedef union packed {
		struct packed {
			opCodeE     op;
			logic [3:0] rDest; // Data register for MEM
			extCodeE    ext;
			logic [3:0] rSrc;  // Address register for MEM, condition for JCOND
		} rForm;
		struct packed {
			opCodeE     op;
			logic [3:0] rDest;
			logic [7:0] imm8;
		} iForm;
	} instU;

	typedef struct packed {
		logic C; // Carry out of add, borrow of sub
		logic L; // Unsigned less-than
		logic F; // Signed overflow
		logic Z; // Zero result or equal operands
		logic N; // Negative result or signed less-than
	} aluFlagsS;

	typedef struct packed {
		aluOpE                  aluOp;
		logic                   useImm;
		logic [`CPU_DATA_W-1:0] immValue;    // Already extended to full width
		logic [3:0]             rDest;
		logic [3:0]             rSrc;
		logic                   writesReg;
		logic                   writesFlags;
		kindE                   kind;
		condE                   cond;
	} decodedS;

	typedef struct packed {
		logic [`CPU_ADDR_W-1:0] addr;
		logic [`CPU_DATA_W-1:0] wrData;
		logic                   write; // High for a store
	} memReqS;

endpackage

`default_nettype wire

// ==== hdl/cpu_cfg.svh ====
`default_nettype none

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Core sizing shared by the package and every stage
////////////////////////////////////////////////////////////////////////////

// Width of the registers and of the data bus
`define CPU_DATA_W 16

// Number of general purpose registers, addressed by the 4-bit fields
`define CPU_REG_N 16

`define CPU_ADDR_W 16 // Program counter and data address width

`endif

`default_nettype wire
